//--- design/eth_pkg.sv
/*
 * Ethernet side definitions
 * port count, byte type and the header/FCS cut lengths
 */
package eth_pkg;

    // number of MAC ports on the bridge
    localparam int ETH_PORTS = 4;

    // bytes dropped at the head of every received frame
    localparam int CUT_HEAD = 8;

    // trailing FCS bytes
    localparam int CUT_TAIL = 4;

    // byte index counter only needs to reach the first kept position
    localparam int CUT_IDX_W = $clog2(CUT_HEAD + CUT_TAIL + 1);

    typedef logic [7:0] eth_byte_t;

    typedef logic [ETH_PORTS-1:0] port_mask_t;  // one bit per port

    typedef logic [CUT_IDX_W-1:0] cut_idx_t;

endpackage

//--- design/uplink_pkg.sv
/*
 * Uplink side definitions
 * port tag and credit counter for the shared serial channel
 */
package uplink_pkg;

    // credits owned by the bridge right after reset
    localparam int UP_CREDITS = 8;

    typedef logic [1:0] up_port_t;  // tag carried with every byte

    // wide enough for UP_CREDITS, the far end never returns more
    typedef logic [3:0] up_credit_t;

endpackage

//--- design/frame_fifo.sv
`timescale 1ns/10ps

/*
 * Frame FIFO: circular buffer of byte plus last flag
 * frame_ready_o is high while at least one complete frame is stored
 */
module frame_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic               clk125M,
    input  logic               rst_n_i,
    input  logic               clear_i,
    input  eth_pkg::eth_byte_t wr_data_i,
    input  logic               wr_last_i,
    input  logic               wr_en_i,
    input  logic               rd_en_i,
    output eth_pkg::eth_byte_t rd_data_o,
    output logic               rd_last_o,
    output logic               empty_o,
    output logic               frame_ready_o
);

localparam int AW = $clog2(FIFO_DEPTH);

eth_pkg::eth_byte_t data_mem [FIFO_DEPTH];
logic               last_mem [FIFO_DEPTH];
logic [AW:0]        wr_ptr_q;   // extra msb tells full from empty
logic [AW:0]        rd_ptr_q;
logic [AW:0]        frame_cnt_q;  // last flags currently stored
logic               full;
logic               wr_ok;
logic               rd_ok;

assign empty_o = (wr_ptr_q == rd_ptr_q);
assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

assign wr_ok = wr_en_i && !full && !clear_i;
assign rd_ok = rd_en_i && !empty_o && !clear_i;

// show-ahead, head entry always on the outputs
assign rd_data_o     = data_mem[rd_ptr_q[AW-1:0]];
assign rd_last_o     = last_mem[rd_ptr_q[AW-1:0]];
assign frame_ready_o = (frame_cnt_q != '0);

always_ff @(posedge clk125M) begin
    if (wr_ok) begin
        data_mem[wr_ptr_q[AW-1:0]] <= wr_data_i;
        last_mem[wr_ptr_q[AW-1:0]] <= wr_last_i;
    end
end

always_ff @(posedge clk125M) begin
    if (!rst_n_i || clear_i) begin
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
        frame_cnt_q <= '0;
    end else begin
        if (wr_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (rd_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        // one frame in, one frame out, or both in the same cycle
        frame_cnt_q <= frame_cnt_q + (AW+1)'(wr_ok && wr_last_i)
                                   - (AW+1)'(rd_ok && rd_last_o);
    end
end

endmodule

//--- design/rx_payload_cut.sv
`timescale 1ns/10ps

/*
 * Receive payload cutter
 * drops CUT_HEAD leading bytes and the CUT_TAIL byte FCS of each MAC frame
 */
module rx_payload_cut (
    input  logic               clk125M,
    input  logic               rst_n_i,
    input  eth_pkg::eth_byte_t rx_data_i,
    input  logic               rx_den_i,
    input  logic               rx_sof_i,
    input  logic               rx_eof_i,
    output eth_pkg::eth_byte_t cut_data_o,
    output logic               cut_valid_o,
    output logic               cut_last_o
);

eth_pkg::eth_byte_t dly_q [eth_pkg::CUT_TAIL];  // [0] newest
eth_pkg::cut_idx_t  idx_q;      // bytes taken so far, saturating
eth_pkg::cut_idx_t  cur_idx;    // index of the byte on rx_data_i
logic               keep;

// ----------------------------------------------------------------------
// byte index within the frame
// ----------------------------------------------------------------------
assign cur_idx = rx_sof_i ? '0 : idx_q;

// the oldest delayed byte is released once it lies past the header;
// a byte at index cur_idx always has CUT_TAIL newer bytes behind it
// only if cur_idx itself is that far in
assign keep = rx_den_i &&
              (cur_idx >= eth_pkg::cut_idx_t'(eth_pkg::CUT_HEAD + eth_pkg::CUT_TAIL));

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        idx_q <= '0;
    end else if (rx_den_i) begin
        if (cur_idx < eth_pkg::cut_idx_t'(eth_pkg::CUT_HEAD + eth_pkg::CUT_TAIL)) begin
            idx_q <= cur_idx + 1'b1;
        end else begin
            idx_q <= cur_idx;  // saturate, every later byte is past the cut
        end
    end
end

// ----------------------------------------------------------------------
// FCS delay line
// ----------------------------------------------------------------------
always_ff @(posedge clk125M) begin
    if (rx_den_i) begin
        dly_q[0] <= rx_data_i;
        for (int i = 1; i < eth_pkg::CUT_TAIL; i++) begin
            dly_q[i] <= dly_q[i-1];
        end
    end
end

always_ff @(posedge clk125M) begin
    cut_data_o <= dly_q[eth_pkg::CUT_TAIL-1];
end

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        cut_valid_o <= 1'b0;
        cut_last_o  <= 1'b0;
    end else begin
        cut_valid_o <= keep;
        cut_last_o  <= keep && rx_eof_i;  // eof pushes out the last kept byte
    end
end

endmodule

//--- design/tx_frame_feeder.sv
`timescale 1ns/10ps

/*
 * Transmit frame feeder
 * requests the MAC, then streams one stored frame with sof/eof markers
 */
module tx_frame_feeder (
    input  logic               clk125M,
    input  logic               rst_n_i,
    input  logic               frame_ready_i,
    input  eth_pkg::eth_byte_t fifo_data_i,
    input  logic               fifo_last_i,
    output logic               fifo_rd_o,
    output logic               mac_tx_rq_o,
    input  logic               mac_tx_ack_i,
    output eth_pkg::eth_byte_t mac_tx_data_o,
    output logic               mac_tx_valid_o,
    output logic               mac_tx_sof_o,
    output logic               mac_tx_eof_o
);

typedef enum logic [1:0] {
    FEED_IDLE,
    FEED_REQ,
    FEED_STREAM
} feed_state_t;

feed_state_t state_q;
logic        first;

// frame_ready_i stays up until the last byte leaves, so it also
// guards against a FIFO cleared under our feet
assign first     = (state_q == FEED_REQ) && mac_tx_ack_i;
assign fifo_rd_o = frame_ready_i && (first || (state_q == FEED_STREAM));

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        state_q     <= FEED_IDLE;
        mac_tx_rq_o <= 1'b0;
    end else begin
        case (state_q)
            FEED_IDLE: begin
                if (frame_ready_i) begin
                    state_q     <= FEED_REQ;
                    mac_tx_rq_o <= 1'b1;
                end
            end
            FEED_REQ, FEED_STREAM: begin
                if (!frame_ready_i || (fifo_rd_o && fifo_last_i)) begin
                    state_q     <= FEED_IDLE;
                    mac_tx_rq_o <= 1'b0;  // falls together with eof
                end else if (first) begin
                    state_q <= FEED_STREAM;
                end
            end
            default: state_q <= FEED_IDLE;
        endcase
    end
end

always_ff @(posedge clk125M) begin
    mac_tx_data_o <= fifo_data_i;
end

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        mac_tx_valid_o <= 1'b0;
        mac_tx_sof_o   <= 1'b0;
        mac_tx_eof_o   <= 1'b0;
    end else begin
        mac_tx_valid_o <= fifo_rd_o;
        mac_tx_sof_o   <= fifo_rd_o && first;
        mac_tx_eof_o   <= fifo_rd_o && fifo_last_i;
    end
end

endmodule

//--- design/uplink_switch.sv
`timescale 1ns/10ps

/*
 * Uplink switch
 * round-robin egress of whole frames under credit control, tag steering on ingress
 */
module uplink_switch (
    input  logic                                       clk125M,
    input  logic                                       rst_n_i,
    input  eth_pkg::port_mask_t                        frame_ready_i,
    input  eth_pkg::eth_byte_t [eth_pkg::ETH_PORTS-1:0] fifo_data_i,
    input  eth_pkg::port_mask_t                        fifo_last_i,
    output eth_pkg::port_mask_t                        fifo_rd_o,
    output eth_pkg::eth_byte_t                         up_tx_data_o,
    output uplink_pkg::up_port_t                       up_tx_port_o,
    output logic                                       up_tx_valid_o,
    output logic                                       up_tx_last_o,
    input  logic                                       up_tx_credit_i,
    input  eth_pkg::eth_byte_t                         up_rx_data_i,
    input  uplink_pkg::up_port_t                       up_rx_port_i,
    input  logic                                       up_rx_valid_i,
    input  logic                                       up_rx_last_i,
    output eth_pkg::eth_byte_t                         ing_data_o,
    output logic                                       ing_last_o,
    output eth_pkg::port_mask_t                        ing_wr_o
);

typedef enum logic {
    SW_IDLE,
    SW_SEND
} sw_state_t;

sw_state_t              state_q;
uplink_pkg::up_port_t   cur_q;      // port granted, or last served when idle
uplink_pkg::up_credit_t credit_q;
uplink_pkg::up_port_t   next_port;
logic                   next_found;
logic                   pop;

// ----------------------------------------------------------------------
// egress arbitration
// ----------------------------------------------------------------------
always_comb begin
    uplink_pkg::up_port_t cand;
    cand       = cur_q;
    next_port  = cur_q;
    next_found = 1'b0;
    // search starts one past the port served last
    for (int i = 1; i <= eth_pkg::ETH_PORTS; i++) begin
        cand = uplink_pkg::up_port_t'((int'(cur_q) + i) % eth_pkg::ETH_PORTS);
        if (!next_found && frame_ready_i[cand]) begin
            next_port  = cand;
            next_found = 1'b1;
        end
    end
end

assign pop = (state_q == SW_SEND) && (credit_q != '0) && frame_ready_i[cur_q];

always_comb begin
    fifo_rd_o        = '0;
    fifo_rd_o[cur_q] = pop;
end

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        state_q  <= SW_IDLE;
        cur_q    <= '0;
        credit_q <= uplink_pkg::up_credit_t'(uplink_pkg::UP_CREDITS);
    end else begin
        credit_q <= credit_q - uplink_pkg::up_credit_t'(pop)
                             + uplink_pkg::up_credit_t'(up_tx_credit_i);
        if (state_q == SW_IDLE) begin
            if (next_found) begin
                state_q <= SW_SEND;
                cur_q   <= next_port;
            end
        end else if (!frame_ready_i[cur_q] || (pop && fifo_last_i[cur_q])) begin
            state_q <= SW_IDLE;  // frame done or port went down
        end
    end
end

always_ff @(posedge clk125M) begin
    up_tx_data_o <= fifo_data_i[cur_q];
    up_tx_port_o <= cur_q;
end

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        up_tx_valid_o <= 1'b0;
        up_tx_last_o  <= 1'b0;
    end else begin
        up_tx_valid_o <= pop;
        up_tx_last_o  <= pop && fifo_last_i[cur_q];
    end
end

// ----------------------------------------------------------------------
// ingress steering, no back-pressure
// ----------------------------------------------------------------------
always_ff @(posedge clk125M) begin
    ing_data_o <= up_rx_data_i;
    ing_last_o <= up_rx_last_i;
end

always_ff @(posedge clk125M) begin
    if (!rst_n_i) begin
        ing_wr_o <= '0;
    end else begin
        ing_wr_o               <= '0;
        ing_wr_o[up_rx_port_i] <= up_rx_valid_i;
    end
end

endmodule

//--- design/eth_uplink_bridge.sv
`timescale 1ns/10ps

/*
 * Ethernet to uplink bridge, top level
 * per-port cut, FIFOs and feeder around one shared uplink switch
 */
module eth_uplink_bridge (
    input  logic                                        clk125M,
    input  logic                                        rst_n_i,
    input  eth_pkg::port_mask_t                         port_en_i,
    input  eth_pkg::port_mask_t                         mac_link_i,
    input  logic                                        up_channel_up_i,
    // MAC receive
    input  eth_pkg::eth_byte_t [eth_pkg::ETH_PORTS-1:0] mac_rx_data_i,
    input  eth_pkg::port_mask_t                         mac_rx_den_i,
    input  eth_pkg::port_mask_t                         mac_rx_sof_i,
    input  eth_pkg::port_mask_t                         mac_rx_eof_i,
    // MAC transmit
    output eth_pkg::port_mask_t                         mac_tx_rq_o,
    input  eth_pkg::port_mask_t                         mac_tx_ack_i,
    output eth_pkg::eth_byte_t [eth_pkg::ETH_PORTS-1:0] mac_tx_data_o,
    output eth_pkg::port_mask_t                         mac_tx_valid_o,
    output eth_pkg::port_mask_t                         mac_tx_sof_o,
    output eth_pkg::port_mask_t                         mac_tx_eof_o,
    // uplink egress
    output eth_pkg::eth_byte_t                          up_tx_data_o,
    output uplink_pkg::up_port_t                        up_tx_port_o,
    output logic                                        up_tx_valid_o,
    output logic                                        up_tx_last_o,
    input  logic                                        up_tx_credit_i,
    // uplink ingress
    input  eth_pkg::eth_byte_t                          up_rx_data_i,
    input  uplink_pkg::up_port_t                        up_rx_port_i,
    input  logic                                        up_rx_valid_i,
    input  logic                                        up_rx_last_i
);

eth_pkg::port_mask_t                         port_active;
eth_pkg::eth_byte_t [eth_pkg::ETH_PORTS-1:0] rx_fifo_data;
eth_pkg::port_mask_t                         rx_fifo_last;
eth_pkg::port_mask_t                         rx_frame_ready;
eth_pkg::port_mask_t                         rx_fifo_rd;
eth_pkg::eth_byte_t                          ing_data;
logic                                        ing_last;
eth_pkg::port_mask_t                         ing_wr;

// a port passes traffic only with enable, link and channel all up
assign port_active = port_en_i & mac_link_i & {eth_pkg::ETH_PORTS{up_channel_up_i}};

genvar p;
generate
    for (p = 0; p < eth_pkg::ETH_PORTS; p++) begin : g_port
        eth_pkg::eth_byte_t cut_data;
        logic               cut_valid;
        logic               cut_last;
        eth_pkg::eth_byte_t tx_fifo_data;
        logic               tx_fifo_last;
        logic               tx_frame_ready;
        logic               tx_fifo_rd;

        rx_payload_cut u_cut (
            .clk125M     (clk125M),
            .rst_n_i     (rst_n_i),
            .rx_data_i   (mac_rx_data_i[p]),
            .rx_den_i    (mac_rx_den_i[p]),
            .rx_sof_i    (mac_rx_sof_i[p]),
            .rx_eof_i    (mac_rx_eof_i[p]),
            .cut_data_o  (cut_data),
            .cut_valid_o (cut_valid),
            .cut_last_o  (cut_last)
        );

        frame_fifo u_rx_fifo (  // toward the uplink
            .clk125M       (clk125M),
            .rst_n_i       (rst_n_i),
            .clear_i       (!port_active[p]),
            .wr_data_i     (cut_data),
            .wr_last_i     (cut_last),
            .wr_en_i       (cut_valid),
            .rd_en_i       (rx_fifo_rd[p]),
            .rd_data_o     (rx_fifo_data[p]),
            .rd_last_o     (rx_fifo_last[p]),
            .empty_o       (),
            .frame_ready_o (rx_frame_ready[p])
        );

        frame_fifo u_tx_fifo (  // toward the MAC
            .clk125M       (clk125M),
            .rst_n_i       (rst_n_i),
            .clear_i       (!port_active[p]),
            .wr_data_i     (ing_data),
            .wr_last_i     (ing_last),
            .wr_en_i       (ing_wr[p]),
            .rd_en_i       (tx_fifo_rd),
            .rd_data_o     (tx_fifo_data),
            .rd_last_o     (tx_fifo_last),
            .empty_o       (),
            .frame_ready_o (tx_frame_ready)
        );

        tx_frame_feeder u_feeder (
            .clk125M        (clk125M),
            .rst_n_i        (rst_n_i),
            .frame_ready_i  (tx_frame_ready),
            .fifo_data_i    (tx_fifo_data),
            .fifo_last_i    (tx_fifo_last),
            .fifo_rd_o      (tx_fifo_rd),
            .mac_tx_rq_o    (mac_tx_rq_o[p]),
            .mac_tx_ack_i   (mac_tx_ack_i[p]),
            .mac_tx_data_o  (mac_tx_data_o[p]),
            .mac_tx_valid_o (mac_tx_valid_o[p]),
            .mac_tx_sof_o   (mac_tx_sof_o[p]),
            .mac_tx_eof_o   (mac_tx_eof_o[p])
        );
    end
endgenerate

uplink_switch u_switch (
    .clk125M        (clk125M),
    .rst_n_i        (rst_n_i),
    .frame_ready_i  (rx_frame_ready),
    .fifo_data_i    (rx_fifo_data),
    .fifo_last_i    (rx_fifo_last),
    .fifo_rd_o      (rx_fifo_rd),
    .up_tx_data_o   (up_tx_data_o),
    .up_tx_port_o   (up_tx_port_o),
    .up_tx_valid_o  (up_tx_valid_o),
    .up_tx_last_o   (up_tx_last_o),
    .up_tx_credit_i (up_tx_credit_i),
    .up_rx_data_i   (up_rx_data_i),
    .up_rx_port_i   (up_rx_port_i),
    .up_rx_valid_i  (up_rx_valid_i),
    .up_rx_last_i   (up_rx_last_i),
    .ing_data_o     (ing_data),
    .ing_last_o     (ing_last),
    .ing_wr_o       (ing_wr)
);

endmodule

//--- bench/tb_eth_uplink_bridge.sv
`timescale 1ns/10ps

/*
 * Testbench for the Ethernet to uplink bridge
 * LFSR stimulus on both sides, checked against per-port queues and a credit model
 */
module tb_eth_uplink_bridge;

localparam int NP        = eth_pkg::ETH_PORTS;
localparam int FIFO_ROOM = 64;     // default frame_fifo depth
localparam int WAIT_MAX  = 4000;   // cycles per wait

logic                        clk125M;
logic                        rst_n;
eth_pkg::port_mask_t         port_en;
eth_pkg::port_mask_t         mac_link;
logic                        channel_up;
eth_pkg::eth_byte_t [NP-1:0] mac_rx_data;
eth_pkg::port_mask_t         mac_rx_den;
eth_pkg::port_mask_t         mac_rx_sof;
eth_pkg::port_mask_t         mac_rx_eof;
eth_pkg::port_mask_t         mac_tx_rq;
eth_pkg::port_mask_t         mac_tx_ack;
eth_pkg::eth_byte_t [NP-1:0] mac_tx_data;
eth_pkg::port_mask_t         mac_tx_valid;
eth_pkg::port_mask_t         mac_tx_sof;
eth_pkg::port_mask_t         mac_tx_eof;
eth_pkg::eth_byte_t          up_tx_data;
uplink_pkg::up_port_t        up_tx_port;
logic                        up_tx_valid;
logic                        up_tx_last;
logic                        up_tx_credit;
eth_pkg::eth_byte_t          up_rx_data;
uplink_pkg::up_port_t        up_rx_port;
logic                        up_rx_valid;
logic                        up_rx_last;

// ----------------------------------------------------------------------
// reference model state
// ----------------------------------------------------------------------
logic [15:0]          lfsr_q;
logic [8:0]           exp_up  [NP][$];  // {last, byte} per port
logic [8:0]           exp_mac [NP][$];
int                   credit_model;     // credits the DUT should hold
int                   credits_owed;     // bytes seen, not yet returned
logic                 credit_d;
logic                 hold_credits;
logic                 up_in_frame;
uplink_pkg::up_port_t up_cur_port;
logic [NP-1:0]        mac_in_frame;
logic [NP-1:0]        rq_seen;
logic [NP-1:0]        eof_seen;
int                   ack_dly [NP];     // -1 while no delay is picked
int                   data_errs;
int                   proto_errs;
int                   timeouts;

eth_uplink_bridge u_dut (
    .clk125M         (clk125M),
    .rst_n_i         (rst_n),
    .port_en_i       (port_en),
    .mac_link_i      (mac_link),
    .up_channel_up_i (channel_up),
    .mac_rx_data_i   (mac_rx_data),
    .mac_rx_den_i    (mac_rx_den),
    .mac_rx_sof_i    (mac_rx_sof),
    .mac_rx_eof_i    (mac_rx_eof),
    .mac_tx_rq_o     (mac_tx_rq),
    .mac_tx_ack_i    (mac_tx_ack),
    .mac_tx_data_o   (mac_tx_data),
    .mac_tx_valid_o  (mac_tx_valid),
    .mac_tx_sof_o    (mac_tx_sof),
    .mac_tx_eof_o    (mac_tx_eof),
    .up_tx_data_o    (up_tx_data),
    .up_tx_port_o    (up_tx_port),
    .up_tx_valid_o   (up_tx_valid),
    .up_tx_last_o    (up_tx_last),
    .up_tx_credit_i  (up_tx_credit),
    .up_rx_data_i    (up_rx_data),
    .up_rx_port_i    (up_rx_port),
    .up_rx_valid_i   (up_rx_valid),
    .up_rx_last_i    (up_rx_last)
);

always #4 clk125M = ~clk125M;

// galois form of x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
endfunction

function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v      = (v << 1) | {31'b0, lfsr_q[0]};
        lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
endfunction

function automatic logic port_active(input int p);
    return port_en[p] && mac_link[p] && channel_up;
endfunction

function automatic int queued(input logic to_uplink, input int p);
    return to_uplink ? exp_up[p].size() : exp_mac[p].size();
endfunction

function automatic logic all_drained();
    logic done;
    done = !up_in_frame && (mac_in_frame == '0);
    for (int p = 0; p < NP; p++) begin
        done = done && (exp_up[p].size() == 0) && (exp_mac[p].size() == 0);
    end
    return done;
endfunction

task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
        data_errs++;
        $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
    end
endtask

task automatic report_fault(input string what);
    proto_errs++;
    $display("at %0t: %s", $time, what);
endtask

task automatic finish_test();
    $display("checks done: %0d data errors, %0d protocol errors, %0d timeouts",
             data_errs, proto_errs, timeouts);
    if (data_errs + proto_errs + timeouts == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
endtask

// keeps the buffer of port p from overflowing
task automatic wait_room(input logic to_uplink, input int p, input int n);
    int cnt;
    cnt = 0;
    while (queued(to_uplink, p) + n > FIFO_ROOM && cnt < WAIT_MAX) begin
        @(posedge clk125M);
        cnt++;
    end
    if (queued(to_uplink, p) + n > FIFO_ROOM) begin
        timeouts++;
        $display("timeout: buffer of port %0d never drained", p);
        finish_test();
    end
endtask

task automatic wait_drained();
    int cnt;
    cnt = 0;
    while (!all_drained() && cnt < WAIT_MAX) begin
        @(posedge clk125M);
        cnt++;
    end
    if (!all_drained()) begin
        timeouts++;
        $display("timeout: expected frames never came out of the bridge");
        finish_test();
    end else begin
        repeat (20) @(posedge clk125M);  // room for stray output
        #1;
    end
endtask

// egress must run dry while no credit comes back
task automatic wait_credits_spent();
    int cnt;
    cnt = 0;
    while (credit_model != 0 && cnt < WAIT_MAX) begin
        @(posedge clk125M);
        cnt++;
    end
    assert (credit_model == 0) else report_fault("egress did not use up its credits");
endtask

// ----------------------------------------------------------------------
// stimulus
// ----------------------------------------------------------------------
task automatic send_rx_frame(input int p, input int len);
    eth_pkg::eth_byte_t b;
    int                 kept;
    kept = len - eth_pkg::CUT_HEAD - eth_pkg::CUT_TAIL;
    if (port_active(p) && kept > 0) begin
        wait_room(1'b1, p, kept);
    end
    for (int k = 0; k < len; k++) begin
        b = eth_pkg::eth_byte_t'(rand_bits(8));
        if (port_active(p) && k >= eth_pkg::CUT_HEAD && k < len - eth_pkg::CUT_TAIL) begin
            exp_up[p].push_back({k == len - 1 - eth_pkg::CUT_TAIL, b});
        end
        @(posedge clk125M);
        #1;
        mac_rx_data[p] = b;
        mac_rx_den[p]  = 1'b1;
        mac_rx_sof[p]  = (k == 0);
        mac_rx_eof[p]  = (k == len - 1);
    end
    @(posedge clk125M);
    #1;
    mac_rx_den[p] = 1'b0;
    mac_rx_sof[p] = 1'b0;
    mac_rx_eof[p] = 1'b0;
endtask

task automatic send_ing_frame(input int p, input int len);
    eth_pkg::eth_byte_t b;
    if (port_active(p)) begin
        wait_room(1'b0, p, len);
    end
    for (int k = 0; k < len; k++) begin
        b = eth_pkg::eth_byte_t'(rand_bits(8));
        if (port_active(p)) begin
            exp_mac[p].push_back({k == len - 1, b});
        end
        @(posedge clk125M);
        #1;
        up_rx_data  = b;
        up_rx_port  = uplink_pkg::up_port_t'(p);
        up_rx_valid = 1'b1;
        up_rx_last  = (k == len - 1);
    end
    @(posedge clk125M);
    #1;
    up_rx_valid = 1'b0;
    up_rx_last  = 1'b0;
endtask

task automatic mixed_traffic(input int n);
    fork
        for (int i = 0; i < n; i++) begin
            send_rx_frame(int'(rand_bits(2)), 4 + int'(rand_bits(6) % 37));
        end
        for (int i = 0; i < n; i++) begin
            send_ing_frame(int'(rand_bits(2)), 4 + int'(rand_bits(6) % 37));
        end
    join
endtask

// credit return with random gaps
always @(posedge clk125M) begin
    #1;
    if (rst_n && !hold_credits && credits_owed > 0 && rand_bits(2) != 0) begin
        up_tx_credit = 1'b1;
        credits_owed--;
    end else begin
        up_tx_credit = 1'b0;
    end
end

// MAC side ack after a random delay and held until eof
always @(posedge clk125M) begin
    #1;
    for (int p = 0; p < NP; p++) begin
        if (mac_tx_ack[p]) begin
            if (eof_seen[p]) begin
                mac_tx_ack[p] = 1'b0;
                eof_seen[p]   = 1'b0;
            end
        end else if (rst_n && rq_seen[p]) begin
            if (ack_dly[p] < 0) begin
                ack_dly[p] = int'(rand_bits(3));
            end else if (ack_dly[p] == 0) begin
                mac_tx_ack[p] = 1'b1;
                ack_dly[p]    = -1;
            end else begin
                ack_dly[p]--;
            end
        end
    end
end

// ----------------------------------------------------------------------
// output monitor sampled mid cycle
// ----------------------------------------------------------------------
always @(negedge clk125M) begin
    logic [8:0] e;
    if (rst_n) begin
        if (up_tx_valid) begin
            assert (credit_model > 0) else report_fault("up_tx_valid_o high with no credit left");
            assert (!up_in_frame || up_tx_port == up_cur_port)
                else report_fault("uplink frames from two ports interleaved");
            assert (exp_up[int'(up_tx_port)].size() != 0)
                else report_fault($sformatf("unexpected uplink byte for port %0d", up_tx_port));
            if (exp_up[int'(up_tx_port)].size() != 0) begin
                e = exp_up[int'(up_tx_port)].pop_front();
                check_value("up_tx_data_o", int'(up_tx_data), int'(e[7:0]));
                check_value("up_tx_last_o", int'(up_tx_last), int'(e[8]));
            end
            up_in_frame  = !up_tx_last;
            up_cur_port  = up_tx_port;
            credits_owed++;
        end
        credit_model = credit_model - int'(up_tx_valid) + int'(credit_d);
        credit_d     = up_tx_credit;  // counted by the DUT one edge later

        for (int p = 0; p < NP; p++) begin
            rq_seen[p] = mac_tx_rq[p];
            if (mac_tx_valid[p]) begin
                assert (mac_tx_ack[p])
                    else report_fault($sformatf("port %0d sent data before ack", p));
                assert (exp_mac[p].size() != 0)
                    else report_fault($sformatf("unexpected MAC byte on port %0d", p));
                if (exp_mac[p].size() != 0) begin
                    e = exp_mac[p].pop_front();
                    check_value($sformatf("mac_tx_data_o[%0d]", p), int'(mac_tx_data[p]),
                                int'(e[7:0]));
                    check_value($sformatf("mac_tx_sof_o[%0d]", p), int'(mac_tx_sof[p]),
                                int'(!mac_in_frame[p]));
                    check_value($sformatf("mac_tx_eof_o[%0d]", p), int'(mac_tx_eof[p]),
                                int'(e[8]));
                    // request held through the frame, gone with eof
                    check_value($sformatf("mac_tx_rq_o[%0d]", p), int'(mac_tx_rq[p]),
                                int'(!e[8]));
                end
                mac_in_frame[p] = !mac_tx_eof[p];
                eof_seen[p]     = mac_tx_eof[p];
            end else begin
                assert (!mac_in_frame[p])
                    else report_fault($sformatf("gap inside a MAC frame on port %0d", p));
            end
        end
    end
end

initial begin
    clk125M      = 1'b0;
    rst_n        = 1'b0;
    port_en      = '1;
    mac_link     = '1;
    channel_up   = 1'b1;
    mac_rx_data  = '0;
    mac_rx_den   = '0;
    mac_rx_sof   = '0;
    mac_rx_eof   = '0;
    mac_tx_ack   = '0;
    up_tx_credit = 1'b0;
    up_rx_data   = '0;
    up_rx_port   = '0;
    up_rx_valid  = 1'b0;
    up_rx_last   = 1'b0;
    lfsr_q       = 16'd19603;
    credit_model = uplink_pkg::UP_CREDITS;
    credits_owed = 0;
    credit_d     = 1'b0;
    hold_credits = 1'b0;
    up_in_frame  = 1'b0;
    up_cur_port  = '0;
    mac_in_frame = '0;
    rq_seen      = '0;
    eof_seen     = '0;
    ack_dly      = '{default: -1};
    data_errs    = 0;
    proto_errs   = 0;
    timeouts     = 0;
    repeat (5) @(posedge clk125M);
    #1;
    rst_n = 1'b1;

    mixed_traffic(16);  // all ports up
    wait_drained();

    // credit starvation with one long frame on each of three ports
    hold_credits = 1'b1;
    for (int p = 0; p < 3; p++) begin
        send_rx_frame(p, 30 + int'(rand_bits(6) % 11));
    end
    wait_credits_spent();
    hold_credits = 1'b0;
    wait_drained();

    port_en  = 4'b1101;  // port 1 disabled
    mac_link = 4'b0111;  // port 3 link down
    mixed_traffic(12);
    wait_drained();

    channel_up = 1'b0;
    mixed_traffic(6);
    wait_drained();
    finish_test();
end

endmodule

//--- eth_uplink_bridge.f
design/eth_pkg.sv
design/uplink_pkg.sv
design/frame_fifo.sv
design/rx_payload_cut.sv
design/tx_frame_feeder.sv
design/uplink_switch.sv
design/eth_uplink_bridge.sv
bench/tb_eth_uplink_bridge.sv

//--- Makefile
TOP = tb_eth_uplink_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f eth_uplink_bridge.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
